/* hdl/chip_pkg.sv */
// Shared constants for the teaching SoC, covering UART timing, command opcodes and JTAG codes.
package chip_pkg;

  localparam int unsigned CLKS_PER_BIT = 8;
  localparam int unsigned HALF_BIT     = CLKS_PER_BIT / 2;
  localparam int unsigned BIT_CNT_W    = $clog2(CLKS_PER_BIT);

  // Opcodes live in bits 7 to 6 of a command byte.
  localparam logic [1:0] OP_SET_STATUS  = 2'd0;
  localparam logic [1:0] OP_READ_COUNT  = 2'd1;
  localparam logic [1:0] OP_ECHO        = 2'd2;
  localparam logic [1:0] OP_CLEAR_COUNT = 2'd3;
  localparam logic [1:0] ECHO_TAG       = 2'b10;

  localparam int unsigned         IR_WIDTH     = 4;
  localparam logic [IR_WIDTH-1:0] IR_IDCODE    = 4'b0001;
  localparam logic [IR_WIDTH-1:0] IR_BYPASS    = 4'b1111;
  localparam logic [IR_WIDTH-1:0] IR_CAPTURE   = 4'b0101;
  localparam logic [31:0]         IDCODE_VALUE = 32'h1C0C_0DB3; // Bit 0 is set as 1149.1 requires.

  // TAP controller states.
  localparam logic [3:0] TAP_RESET    = 4'h0;
  localparam logic [3:0] TAP_IDLE     = 4'h1;
  localparam logic [3:0] TAP_SEL_DR   = 4'h2;
  localparam logic [3:0] TAP_CAP_DR   = 4'h3;
  localparam logic [3:0] TAP_SHIFT_DR = 4'h4;
  localparam logic [3:0] TAP_EXIT1_DR = 4'h5;
  localparam logic [3:0] TAP_PAUSE_DR = 4'h6;
  localparam logic [3:0] TAP_EXIT2_DR = 4'h7;
  localparam logic [3:0] TAP_UPD_DR   = 4'h8;
  localparam logic [3:0] TAP_SEL_IR   = 4'h9;
  localparam logic [3:0] TAP_CAP_IR   = 4'hA;
  localparam logic [3:0] TAP_SHIFT_IR = 4'hB;
  localparam logic [3:0] TAP_EXIT1_IR = 4'hC;
  localparam logic [3:0] TAP_PAUSE_IR = 4'hD;
  localparam logic [3:0] TAP_EXIT2_IR = 4'hE;
  localparam logic [3:0] TAP_UPD_IR   = 4'hF;

endpackage

/* hdl/io_ring.sv */
// Input ring that synchronizes the reset release and the asynchronous UART and interrupt pins.
module io_ring (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic uart_rx_i,
  input  logic irq0_i,
  output logic rst_sync_n_o,
  output logic uart_rx_o,
  output logic irq0_o
);

  logic [1:0] rst_ff;
  logic [1:0] meta_ff; // Bit 0 is the UART line, bit 1 the interrupt.
  logic [1:0] sync_ff;

  // Reset goes low at once and comes back two clock edges after the pin rises.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_ff <= 2'b00;
    end else begin
      rst_ff <= {rst_ff[0], 1'b1};
    end
  end

  assign rst_sync_n_o = rst_ff[1];

  always_ff @(posedge clk_i) begin
    if (!rst_sync_n_o) begin
      meta_ff <= 2'b01; // An idle UART line is high.
      sync_ff <= 2'b01;
    end else begin
      meta_ff <= {irq0_i, uart_rx_i};
      sync_ff <= meta_ff;
    end
  end

  assign uart_rx_o = sync_ff[0];
  assign irq0_o    = sync_ff[1];

endmodule

/* hdl/uart.sv */
// UART 8N1 receiver and transmitter with a one-cycle byte strobe on each side.
module uart (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       rx_i,
  input  logic       tx_start_i,
  input  logic [7:0] tx_byte_i,
  output logic       rx_valid_o,
  output logic [7:0] rx_byte_o,
  output logic       tx_busy_o,
  output logic       tx_o
);
  import chip_pkg::*;

  logic                 rx_active;
  logic [BIT_CNT_W-1:0] rx_cnt;
  logic [3:0]           rx_bit; // 0 is the start bit, 1 to 8 data, 9 the stop bit.
  logic                 rx_sample;

  logic                 tx_load;
  logic                 tx_step;
  logic [BIT_CNT_W-1:0] tx_cnt;
  logic [3:0]           tx_bit;
  logic [8:0]           tx_shift;

  assign rx_sample = rx_active && (rx_cnt == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_active  <= 1'b0;
      rx_cnt     <= '0;
      rx_bit     <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (!rx_active) begin
        if (!rx_i) begin
          // Wait half a bit so every later sample lands mid-bit.
          rx_active <= 1'b1;
          rx_cnt    <= BIT_CNT_W'(HALF_BIT - 1);
          rx_bit    <= '0;
        end
      end else if (!rx_sample) begin
        rx_cnt <= rx_cnt - 1'b1;
      end else begin
        rx_cnt <= BIT_CNT_W'(CLKS_PER_BIT - 1);
        rx_bit <= rx_bit + 1'b1;
        if (rx_bit == 4'd0 && rx_i) begin
          rx_active <= 1'b0; // A glitch, not a real start bit.
        end else if (rx_bit == 4'd9) begin
          rx_active  <= 1'b0;
          rx_valid_o <= rx_i; // A low stop bit means a framing error.
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_sample && rx_bit != 4'd0 && rx_bit != 4'd9) begin
      rx_byte_o <= {rx_i, rx_byte_o[7:1]};
    end
  end

  assign tx_load = !tx_busy_o && tx_start_i;
  assign tx_step = tx_busy_o && (tx_cnt == '0) && (tx_bit != 4'd9);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_busy_o <= 1'b0;
      tx_o      <= 1'b1;
      tx_cnt    <= '0;
      tx_bit    <= '0;
    end else if (tx_load) begin
      tx_busy_o <= 1'b1;
      tx_o      <= 1'b0; // Start bit.
      tx_cnt    <= BIT_CNT_W'(CLKS_PER_BIT - 1);
      tx_bit    <= '0;
    end else if (tx_busy_o) begin
      if (tx_cnt != '0) begin
        tx_cnt <= tx_cnt - 1'b1;
      end else if (tx_bit == 4'd9) begin
        tx_busy_o <= 1'b0;
      end else begin
        tx_o   <= tx_shift[0];
        tx_cnt <= BIT_CNT_W'(CLKS_PER_BIT - 1);
        tx_bit <= tx_bit + 1'b1;
      end
    end
  end

  // The stop bit sits above the data and the register fills with ones.
  always_ff @(posedge clk_i) begin
    if (tx_load) begin
      tx_shift <= {1'b1, tx_byte_i};
    end else if (tx_step) begin
      tx_shift <= {1'b1, tx_shift[8:1]};
    end
  end

endmodule

/* hdl/jtag_tap.sv */
// IEEE 1149.1 test access port with a 4-bit instruction register, IDCODE and BYPASS.
module jtag_tap (
  input  logic tck_i,
  input  logic trst_n_i,
  input  logic tms_i,
  input  logic tdi_i,
  output logic tdo_o
);
  import chip_pkg::*;

  logic [3:0]          state_q;
  logic [3:0]          state_d;
  logic [IR_WIDTH-1:0] ir_q;
  logic [IR_WIDTH-1:0] ir_shift_q;
  logic [31:0]         idcode_q;
  logic                bypass_q;
  logic                sel_idcode;

  always_comb begin
    case (state_q)
      TAP_RESET:    state_d = tms_i ? TAP_RESET    : TAP_IDLE;
      TAP_IDLE:     state_d = tms_i ? TAP_SEL_DR   : TAP_IDLE;
      TAP_SEL_DR:   state_d = tms_i ? TAP_SEL_IR   : TAP_CAP_DR;
      TAP_CAP_DR:   state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_SHIFT_DR: state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_EXIT1_DR: state_d = tms_i ? TAP_UPD_DR   : TAP_PAUSE_DR;
      TAP_PAUSE_DR: state_d = tms_i ? TAP_EXIT2_DR : TAP_PAUSE_DR;
      TAP_EXIT2_DR: state_d = tms_i ? TAP_UPD_DR   : TAP_SHIFT_DR;
      TAP_UPD_DR:   state_d = tms_i ? TAP_SEL_DR   : TAP_IDLE;
      TAP_SEL_IR:   state_d = tms_i ? TAP_RESET    : TAP_CAP_IR;
      TAP_CAP_IR:   state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_SHIFT_IR: state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_EXIT1_IR: state_d = tms_i ? TAP_UPD_IR   : TAP_PAUSE_IR;
      TAP_PAUSE_IR: state_d = tms_i ? TAP_EXIT2_IR : TAP_PAUSE_IR;
      TAP_EXIT2_IR: state_d = tms_i ? TAP_UPD_IR   : TAP_SHIFT_IR;
      TAP_UPD_IR:   state_d = tms_i ? TAP_SEL_DR   : TAP_IDLE;
      default:      state_d = TAP_RESET;
    endcase
  end

  always_comb begin
    case (ir_q)
      IR_IDCODE: sel_idcode = 1'b1;
      IR_BYPASS: sel_idcode = 1'b0;
      default:   sel_idcode = 1'b0; // Unknown codes fall back to the bypass path.
    endcase
  end

  // Test reset forces Test-Logic-Reset at once and selects IDCODE.
  always_ff @(posedge tck_i or negedge trst_n_i) begin
    if (!trst_n_i) begin
      state_q <= TAP_RESET;
      ir_q    <= IR_IDCODE;
    end else begin
      state_q <= state_d;
      if (state_d == TAP_RESET) begin
        ir_q <= IR_IDCODE;
      end else if (state_d == TAP_UPD_IR) begin
        ir_q <= ir_shift_q; // Loaded on the edge that enters Update-IR.
      end
    end
  end

  always_ff @(posedge tck_i) begin
    case (state_q)
      TAP_CAP_IR:   ir_shift_q <= IR_CAPTURE;
      TAP_SHIFT_IR: ir_shift_q <= {tdi_i, ir_shift_q[IR_WIDTH-1:1]};
      TAP_CAP_DR: begin
        if (sel_idcode) idcode_q <= IDCODE_VALUE;
        else            bypass_q <= 1'b0;
      end
      TAP_SHIFT_DR: begin
        if (sel_idcode) idcode_q <= {tdi_i, idcode_q[31:1]};
        else            bypass_q <= tdi_i;
      end
      default: ;
    endcase
  end

  always_ff @(negedge tck_i or negedge trst_n_i) begin
    if (!trst_n_i) begin
      tdo_o <= 1'b0;
    end else begin
      case (state_q)
        TAP_SHIFT_IR: tdo_o <= ir_shift_q[0];
        TAP_SHIFT_DR: tdo_o <= sel_idcode ? idcode_q[0] : bypass_q;
        default:      tdo_o <= 1'b0;
      endcase
    end
  end

endmodule

/* hdl/soc_core.sv */
// SoC core that decodes UART commands, holds the status pin and counts interrupt edges.
module soc_core (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic uart_rx_i,
  input  logic irq0_i,
  input  logic jtag_tck_i,
  input  logic jtag_trst_n_i,
  input  logic jtag_tms_i,
  input  logic jtag_tdi_i,
  output logic jtag_tdo_o,
  output logic uart_tx_o,
  output logic status_o
);
  import chip_pkg::*;

  logic       rx_valid;
  logic [7:0] rx_byte;
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;
  logic       irq_q;
  logic       irq_rise;
  logic [7:0] irq_count;
  logic [1:0] opcode;

  assign opcode   = rx_byte[7:6];
  assign irq_rise = irq0_i & ~irq_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_q     <= 1'b0;
      irq_count <= '0;
      status_o  <= 1'b0;
      tx_start  <= 1'b0;
    end else begin
      irq_q    <= irq0_i;
      tx_start <= 1'b0;
      if (rx_valid && opcode == OP_CLEAR_COUNT) begin
        irq_count <= '0;
      end else if (irq_rise) begin
        irq_count <= irq_count + 1'b1; // Wraps at 256.
      end
      if (rx_valid) begin
        case (opcode)
          OP_SET_STATUS: status_o <= rx_byte[0];
          OP_READ_COUNT: tx_start <= !tx_busy; // Replies are dropped while a frame is out.
          OP_ECHO:       tx_start <= !tx_busy;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_valid) begin
      tx_byte <= (opcode == OP_READ_COUNT) ? irq_count : {ECHO_TAG, rx_byte[5:0]};
    end
  end

  uart i_uart (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .rx_i       ( uart_rx_i ),
    .tx_start_i ( tx_start  ),
    .tx_byte_i  ( tx_byte   ),
    .rx_valid_o ( rx_valid  ),
    .rx_byte_o  ( rx_byte   ),
    .tx_busy_o  ( tx_busy   ),
    .tx_o       ( uart_tx_o )
  );

  jtag_tap i_jtag_tap (
    .tck_i    ( jtag_tck_i    ),
    .trst_n_i ( jtag_trst_n_i ),
    .tms_i    ( jtag_tms_i    ),
    .tdi_i    ( jtag_tdi_i    ),
    .tdo_o    ( jtag_tdo_o    )
  );

endmodule

/* hdl/soc_chip.sv */
// Chip top level that routes the pins through the input ring into the SoC core.
module soc_chip (
  input  logic clk_i,
  input  logic rst_n_i,

  input  logic jtag_tck_i,
  input  logic jtag_trst_n_i,
  input  logic jtag_tms_i,
  input  logic jtag_tdi_i,
  output logic jtag_tdo_o,

  input  logic uart_rx_i,
  output logic uart_tx_o,

  input  logic irq0_i,
  output logic status_o
);

  logic rst_sync_n;
  logic uart_rx_sync;
  logic irq0_sync;

  io_ring i_io_ring (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .uart_rx_i    ( uart_rx_i    ),
    .irq0_i       ( irq0_i       ),
    .rst_sync_n_o ( rst_sync_n   ),
    .uart_rx_o    ( uart_rx_sync ),
    .irq0_o       ( irq0_sync    )
  );

  // The JTAG pins run on their own clock and skip the ring.
  soc_core i_soc_core (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_sync_n    ),
    .uart_rx_i     ( uart_rx_sync  ),
    .irq0_i        ( irq0_sync     ),
    .jtag_tck_i    ( jtag_tck_i    ),
    .jtag_trst_n_i ( jtag_trst_n_i ),
    .jtag_tms_i    ( jtag_tms_i    ),
    .jtag_tdi_i    ( jtag_tdi_i    ),
    .jtag_tdo_o    ( jtag_tdo_o    ),
    .uart_tx_o     ( uart_tx_o     ),
    .status_o      ( status_o      )
  );

endmodule

/* sim/soc_checker.sv */
// Testbench checker that decodes UART replies, samples TDO and compares against expectations.
module soc_checker (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        uart_tx_i,
  input  logic        status_i,
  input  logic        tck_i,
  input  logic        tdo_i,
  input  logic        exp_byte_stb_i,
  input  logic [7:0]  exp_byte_i,
  input  logic        exp_status_stb_i,
  input  logic        exp_status_i,
  input  logic        exp_jtag_stb_i,
  input  logic        exp_jtag_ir_i,
  input  logic [5:0]  exp_jtag_len_i,
  input  logic [31:0] exp_jtag_data_i,
  output logic        idle_o,
  output int          pass_cnt_o,
  output int          fail_cnt_o
);
  import chip_pkg::*;

  localparam int REPLY_LIMIT = 40 * CLKS_PER_BIT; // Command frame, reply frame and slack.

  logic [7:0]  exp_q[$];
  logic [7:0]  exp_head;
  int          wait_cnt;
  logic        dec_busy;
  int          dec_cnt;
  int          dec_bit;
  logic [7:0]  dec_shift;
  logic        tck_q;
  int          jtag_left;
  int          jtag_idx;
  logic [31:0] jtag_got;
  logic [31:0] jtag_exp;
  logic        jtag_ir;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp === got) begin
      pass_cnt_o = pass_cnt_o + 1;
      $display("pass %s 0x%h", name, got);
    end else begin
      fail_cnt_o = fail_cnt_o + 1;
      $display("error %s expected 0x%h got 0x%h", name, exp, got);
    end
  endtask

  initial begin
    pass_cnt_o = 0;
    fail_cnt_o = 0;
    wait_cnt   = 0;
    dec_busy   = 1'b0;
    jtag_left  = 0;
    tck_q      = 1'b0;
    idle_o     = 1'b1;
  end

  always @(posedge clk_i) begin
    if (exp_byte_stb_i) exp_q.push_back(exp_byte_i);
    if (exp_status_stb_i) compare("status_o", {31'd0, exp_status_i}, {31'd0, status_i});
    // A missing reply is given up on after a fixed wait.
    if (exp_q.size() == 0) begin
      wait_cnt = 0;
    end else begin
      wait_cnt = wait_cnt + 1;
      if (wait_cnt > REPLY_LIMIT) begin
        exp_head   = exp_q.pop_front();
        fail_cnt_o = fail_cnt_o + 1;
        $display("no reply byte arrived on uart_tx_o, 0x%h was expected", exp_head);
        wait_cnt = 0;
      end
    end
    if (!dec_busy) begin
      if (rst_n_i && uart_tx_i === 1'b0) begin
        dec_busy = 1'b1;
        dec_cnt  = HALF_BIT;
        dec_bit  = 0;
      end
    end else begin
      dec_cnt = dec_cnt - 1;
      if (dec_cnt == 0) begin
        dec_cnt = CLKS_PER_BIT;
        if (dec_bit == 0 && uart_tx_i) begin
          dec_busy = 1'b0;
        end else if (dec_bit < 9) begin
          if (dec_bit > 0) dec_shift = {uart_tx_i, dec_shift[7:1]};
          dec_bit++;
        end else begin
          dec_busy = 1'b0;
          if (!uart_tx_i) begin
            fail_cnt_o = fail_cnt_o + 1;
            $display("reply frame on uart_tx_o had a low stop bit");
          end else if (exp_q.size() == 0) begin
            fail_cnt_o = fail_cnt_o + 1;
            $display("unexpected reply byte 0x%h on uart_tx_o", dec_shift);
          end else begin
            exp_head = exp_q.pop_front();
            compare("uart_tx_o", {24'd0, exp_head}, {24'd0, dec_shift});
            wait_cnt = 0;
          end
        end
      end
    end
    if (exp_jtag_stb_i) begin
      jtag_left = int'(exp_jtag_len_i);
      jtag_idx  = 0;
      jtag_got  = '0;
      jtag_exp  = exp_jtag_data_i;
      jtag_ir   = exp_jtag_ir_i;
    end else if (jtag_left > 0 && tck_i && !tck_q) begin
      jtag_got[jtag_idx] = tdo_i; // TDO settled on the falling edge before.
      jtag_idx++;
      jtag_left--;
      if (jtag_left == 0) compare(jtag_ir ? "jtag_tdo_o ir" : "jtag_tdo_o dr", jtag_exp, jtag_got);
    end
    tck_q  = tck_i;
    idle_o = (exp_q.size() == 0) && (jtag_left == 0);
  end

endmodule

/* sim/tb_soc_chip.sv */
// Testbench for the SoC chip that replays the pattern file over UART, interrupt and JTAG pins.
module tb_soc_chip;
  import chip_pkg::*;

  logic clk = 1'b0;
  logic rst_n, tck, trst_n, tms, tdi, tdo, rx, tx, irq, status;
  logic byte_stb, status_stb, exp_status, jtag_stb, jtag_ir;
  logic [7:0]  exp_byte;
  logic [5:0]  jtag_len;
  logic [31:0] jtag_data;
  logic        idle;
  int          pass_cnt, fail_cnt;
  int          cycles = 0;
  int          limit = 32'h7fff_ffff;
  byte         kinds[$];
  logic [31:0] f1[$], f2[$], f3[$], f4[$];

  always #5 clk = ~clk;

  soc_chip soc_chip_inst (
    .clk_i(clk), .rst_n_i(rst_n), .jtag_tck_i(tck), .jtag_trst_n_i(trst_n),
    .jtag_tms_i(tms), .jtag_tdi_i(tdi), .jtag_tdo_o(tdo), .uart_rx_i(rx),
    .uart_tx_o(tx), .irq0_i(irq), .status_o(status)
  );

  soc_checker checker_inst (
    .clk_i(clk), .rst_n_i(rst_n), .uart_tx_i(tx), .status_i(status), .tck_i(tck),
    .tdo_i(tdo), .exp_byte_stb_i(byte_stb), .exp_byte_i(exp_byte),
    .exp_status_stb_i(status_stb), .exp_status_i(exp_status), .exp_jtag_stb_i(jtag_stb),
    .exp_jtag_ir_i(jtag_ir), .exp_jtag_len_i(jtag_len), .exp_jtag_data_i(jtag_data),
    .idle_o(idle), .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt)
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles with tests still running", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic send_uart_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0}; // Start bit first, data LSB first.
    for (int i = 0; i < 10; i++) begin
      rx <= frame[i];
      wait_clks(CLKS_PER_BIT);
    end
  endtask

  task automatic tck_cycle(input logic tms_v, input logic tdi_v);
    tms <= tms_v;
    tdi <= tdi_v;
    tck <= 1'b0;
    wait_clks(4);
    tck <= 1'b1;
    wait_clks(4);
  endtask

  task automatic expect_shift(input logic ir, input int n, input logic [31:0] d);
    jtag_stb  <= 1'b1;
    jtag_ir   <= ir;
    jtag_len  <= 6'(n);
    jtag_data <= d;
    wait_clks(1);
    jtag_stb  <= 1'b0;
  endtask

  task automatic shift_bits(input int n, input logic [31:0] d);
    for (int i = 0; i < n; i++) tck_cycle(i == n - 1, d[i]); // Last bit goes to Exit1.
  endtask

  task automatic run_jtag(input logic [31:0] ir, input int n, input logic [31:0] din,
                          input logic [31:0] dout);
    repeat (5) tck_cycle(1'b1, 1'b0);
    tck_cycle(1'b0, 1'b0);
    if (ir < 16) begin
      tck_cycle(1'b1, 1'b0);
      tck_cycle(1'b1, 1'b0);
      tck_cycle(1'b0, 1'b0);
      tck_cycle(1'b0, 1'b0);
      expect_shift(1'b1, IR_WIDTH, 32'h5); // Capture-IR loads 0101.
      shift_bits(IR_WIDTH, ir);
      tck_cycle(1'b1, 1'b0);
      tck_cycle(1'b0, 1'b0);
    end
    tck_cycle(1'b1, 1'b0);
    tck_cycle(1'b0, 1'b0);
    tck_cycle(1'b0, 1'b0);
    expect_shift(1'b0, n, dout);
    shift_bits(n, din);
    tck_cycle(1'b1, 1'b0);
    tck_cycle(1'b0, 1'b0);
    while (!idle) wait_clks(1);
  endtask

  initial begin
    int fd;
    int total;
    byte k;
    string skip;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] v4;
    rst_n      = 1'b0;
    trst_n     = 1'b0;
    tck        = 1'b0;
    tms        = 1'b1;
    tdi        = 1'b0;
    rx         = 1'b1;
    irq        = 1'b0;
    byte_stb   = 1'b0;
    status_stb = 1'b0;
    jtag_stb   = 1'b0;
    jtag_ir    = 1'b0;
    exp_byte   = '0;
    exp_status = 1'b0;
    jtag_len   = '0;
    jtag_data  = '0;
    void'($urandom(32'h71f97883));
    total = 100;
    fd = $fopen("sim/chip_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file sim/chip_patterns.txt");
    end else begin
      while ($fscanf(fd, " %c", k) == 1) begin
        if (k == "#") begin
          void'($fgets(skip, fd));
          continue;
        end
        v1 = '0;
        v2 = '0;
        v3 = '0;
        v4 = '0;
        case (k)
          "U": void'($fscanf(fd, "%h %h %h", v1, v2, v3));
          "S": void'($fscanf(fd, "%h", v1));
          "I": void'($fscanf(fd, "%h", v1));
          default: void'($fscanf(fd, "%h %h %h %h", v1, v2, v3, v4));
        endcase
        kinds.push_back(k);
        f1.push_back(v1);
        f2.push_back(v2);
        f3.push_back(v3);
        f4.push_back(v4);
        case (k)
          "U": total += 40 * CLKS_PER_BIT;
          "I": total += 8 * int'(v1) + 20;
          "J": total += 8 * (30 + int'(v2));
          default: total += 4;
        endcase
      end
      $fclose(fd);
    end
    limit = 3 * total;
    wait_clks(4);
    rst_n  <= 1'b1;
    trst_n <= 1'b1;
    wait_clks(4);
    foreach (kinds[i]) begin
      case (kinds[i])
        "U": begin
          if (f2[i] != 0) begin
            byte_stb <= 1'b1;
            exp_byte <= f3[i][7:0];
            wait_clks(1);
            byte_stb <= 1'b0;
          end
          send_uart_byte(f1[i][7:0]);
          while (!idle) wait_clks(1);
          wait_clks(CLKS_PER_BIT * (2 + int'($urandom % 19)));
        end
        "S": begin
          status_stb <= 1'b1;
          exp_status <= f1[i][0];
          wait_clks(1);
          status_stb <= 1'b0;
          wait_clks(1);
        end
        "I": begin
          for (int p = 0; p < int'(f1[i]); p++) begin
            irq <= 1'b1;
            wait_clks(4);
            irq <= 1'b0;
            wait_clks(4);
          end
          wait_clks(8); // Let the last edge pass the synchronizer.
        end
        default: run_jtag(f1[i], int'(f2[i]), f3[i], f4[i]);
      endcase
    end
    wait_clks(4);
    $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* sim/chip_patterns.txt */
# Columns, all hex: U byte reply_flag expected | S status | I pulses | J ir nbits tdi tdo
# An ir of 10 skips the IR scan. Opcode bits 7:6 are 0 set, 1 read, 2 echo, 3 clear.
S 0
U 81 1 81
U 80 1 80
U BF 1 BF
U 95 1 95
U 01 0 00
S 1
U 00 0 00
S 0
U 3F 0 00
S 1
U C0 0 00
U 40 1 00
I 3
U 40 1 03
I 105
U 40 1 08
U C0 0 00
U 40 1 00
I 7
U 40 1 07
J 10 20 00000000 1C0C0DB3
J 1 20 FFFFFFFF 1C0C0DB3
J F 8 A5 4A
J F 10 1234 2468
J 7 4 F E

/* tb.f */
hdl/chip_pkg.sv
hdl/io_ring.sv
hdl/uart.sv
hdl/jtag_tap.sv
hdl/soc_core.sv
hdl/soc_chip.sv
sim/soc_checker.sv
sim/tb_soc_chip.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing -j 0
TOP       ?= tb_soc_chip
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Test OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
